// ==== compile.f ====
logic/p2r_pkg.sv
logic/coeff_mem.sv
logic/p2r_ctrl.sv
logic/p2r_decompose.sv
logic/t0_packer.sv
logic/p2r_top.sv
tests/tb_clock.sv
tests/p2r_assertions.sv
tests/p2r_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the Power2Round testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module p2r_tb -f compile.f -o p2r_sim \
    && ./obj_dir/p2r_sim > sim.log 2>&1

cat sim.log

grep -q "Verification passed" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

// ==== tests/p2r_stim.txt ====
# T name mode stall runs abort   (stall 1: sk_ready from xorshift, abort 1: zeroize mid run)
# C coefficient t1 t0_encoded    (hex, repeated over the source memory)
T fixed_vals fixed 0 1 0
C 0 0 1000
C fff 0 1
C 1000 0 0
C 1001 1 1fff
C 1fff 1 1001
C 7fe000 3ff 1000
C 2000 1 1000
C 3000 1 0
C 3001 2 1fff
C f4240 7a dc0
C 7fde60 3ff 11a0
C 1e240 f dc0
T fixed_stall fixed 1 1 0
C 1001 1 1fff
C 7fe000 3ff 1000
C fff 0 1
C 3001 2 1fff
T random_twice random 0 2 0
T random_stall random 1 2 0
T boundary boundary 1 1 0
T zeroize_mid random 1 1 1

// ==== tests/p2r_tb.sv ====
// Power2Round testbench

module p2r_tb;
    import p2r_pkg::*;

    localparam int Q = 8380417;

    logic clk, reset_n, zeroize, enable, load_en, sk_ready, pk_wren, done;
    logic [MEM_ADDR_W-1:0]  load_addr;
    logic [COEFF_W-1:0]     load_data;
    logic [PK_ADDR_W-1:0]   pk_addr;
    logic [1:0][T1_W-1:0]   pk_t1;
    sk_word_t               sk_wr;

    string       t_name[$], t_mode[$];
    int          t_stall[$], t_runs[$], t_abort[$], t_cstart[$], t_ccount[$];
    logic [31:0] c_t[$], c_t1[$], c_t0[$];
    logic [T1_W-1:0] exp_t1[SRC_WORDS];
    logic [T0_W-1:0] exp_t0[SRC_WORDS];

    int errors = 0, failed_tests = 0, pk_idx = 0, sk_idx = 0, done_cnt = 0, limit = 0;
    logic parsed = 1'b0, quiet = 1'b0, stall_mode = 1'b0;
    logic [31:0] rng_coef = 32'd94607, rng_ready = 32'd94607;

    tb_clock u_clock (.clk(clk));

    p2r_top i_dut (.clk(clk), .reset_n(reset_n), .zeroize(zeroize), .enable(enable),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .sk_ready(sk_ready), .sk_wr(sk_wr), .pk_wren(pk_wren), .pk_addr(pk_addr),
        .pk_t1(pk_t1), .done(done));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // high part rounds at half of 2^13
    function automatic logic [T1_W-1:0] split_high(input int t);
        return T1_W'((t + 4095) >>> 13);
    endfunction

    function automatic logic [T0_W-1:0] split_low_enc(input int t);
        int t0;
        t0 = t - int'(split_high(t)) * 8192;
        return T0_W'(4096 - t0);
    endfunction

    task automatic note_failure(input string msg);
        $display("error: %s", msg);
        errors++;
    endtask

    task automatic check_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            $display("mismatch %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    // sk_ready toggles only in stall mode
    always @(posedge clk) begin
        #1;
        rng_ready = xorshift(rng_ready);
        sk_ready <= stall_mode ? rng_ready[7] : 1'b1;
    end

    // ------------------------------------------------------------------------
    // output monitor, sampled mid cycle
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (reset_n && pk_wren) begin
            assert (!quiet) else note_failure("pk write after zeroize");
            assert (pk_idx < PK_PAIRS) else note_failure("more pk writes than pairs");
            if (!quiet && pk_idx < PK_PAIRS) begin
                check_value("pk_addr", 64'(pk_addr), 64'(pk_idx));
                check_value("pk_t1[0]", 64'(pk_t1[0]), 64'(exp_t1[2*pk_idx]));
                check_value("pk_t1[1]", 64'(pk_t1[1]), 64'(exp_t1[2*pk_idx+1]));
                pk_idx++;
            end
        end
        if (reset_n && sk_wr.en && sk_ready) begin
            assert (!quiet) else note_failure("sk write after zeroize");
            assert (sk_idx < SK_WORDS) else note_failure("more sk writes than words");
            if (!quiet && sk_idx < SK_WORDS) begin
                check_value("sk_wr.addr", 64'(sk_wr.addr), 64'(sk_idx));
                check_value("sk_wr.data", 64'(sk_wr.data), 64'({exp_t0[4*sk_idx+3],
                    exp_t0[4*sk_idx+2], exp_t0[4*sk_idx+1], exp_t0[4*sk_idx]}));
                sk_idx++;
            end
        end
        if (reset_n && done) done_cnt++;
    end

    task automatic fill_memory(input int i);
        int t;
        for (int a = 0; a < SRC_WORDS; a++) begin
            if (t_mode[i] == "fixed") begin
                t = int'(c_t[t_cstart[i] + a % t_ccount[i]]);
            end else if (t_mode[i] == "random") begin
                rng_coef = xorshift(rng_coef);
                t = int'(rng_coef % 32'(Q));
            end else begin
                // rounding edges spread over the high parts
                t = ((a * 17) % 1023) * 8192 + ((a % 4 == 0) ? 0 : 4094 + a % 4);
            end
            if (t_mode[i] == "fixed") begin
                exp_t1[a] = T1_W'(c_t1[t_cstart[i] + a % t_ccount[i]]);
                exp_t0[a] = T0_W'(c_t0[t_cstart[i] + a % t_ccount[i]]);
            end else begin
                exp_t1[a] = split_high(t);
                exp_t0[a] = split_low_enc(t);
            end
            @(posedge clk);
            #1 load_en = 1'b1;
            load_addr = MEM_ADDR_W'(a);
            load_data = COEFF_W'(t);
        end
        @(posedge clk);
        #1 load_en = 1'b0;
    endtask

    task automatic start_run();
        pk_idx = 0;
        sk_idx = 0;
        done_cnt = 0;
        @(posedge clk);
        #1 enable = 1'b1;
        @(posedge clk);
        #1 enable = 1'b0;
    endtask

    task automatic full_run();
        start_run();
        do @(negedge clk); while (!done);
        assert (sk_idx == SK_WORDS) else note_failure("done came before the last sk write");
        repeat (4) @(negedge clk);
        assert (pk_idx == PK_PAIRS) else note_failure($sformatf("%0d pk writes", pk_idx));
        assert (sk_idx == SK_WORDS) else note_failure($sformatf("%0d sk writes", sk_idx));
        assert (done_cnt == 1) else note_failure($sformatf("done pulsed %0d times", done_cnt));
    endtask

    task automatic abort_run();
        start_run();
        repeat (12) @(posedge clk);
        #1 zeroize = 1'b1;
        @(posedge clk);
        #1 zeroize = 1'b0;
        quiet = 1'b1;
        repeat (20) @(negedge clk);
        quiet = 1'b0;
        assert (done_cnt == 0) else note_failure("done pulsed after zeroize");
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        string line, tag, nm, md;
        int fd, n, s, r, ab, e0;
        logic [31:0] ct, c1, c0;
        reset_n = 1'b0;
        zeroize = 1'b0;
        enable = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        sk_ready = 1'b1;
        fd = $fopen("tests/p2r_stim.txt", "r");
        assert (fd != 0) else note_failure("cannot open tests/p2r_stim.txt");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s", tag);
            if (tag == "T") begin
                n = $sscanf(line, "%s %s %s %d %d %d", tag, nm, md, s, r, ab);
                assert (n == 6) else note_failure("malformed test line in stimulus file");
                t_name.push_back(nm);
                t_mode.push_back(md);
                t_stall.push_back(s);
                t_runs.push_back(r);
                t_abort.push_back(ab);
                t_cstart.push_back(c_t.size());
                t_ccount.push_back(0);
            end else if (tag == "C") begin
                n = $sscanf(line, "%s %h %h %h", tag, ct, c1, c0);
                assert (n == 4) else note_failure("malformed coefficient line in stimulus file");
                c_t.push_back(ct);
                c_t1.push_back(c1);
                c_t0.push_back(c0);
                t_ccount[t_ccount.size()-1]++;
            end
        end
        if (fd != 0) $fclose(fd);
        // three runs per test at most, each stall adds a cycle or so per word
        limit = (t_name.size() + 1) * 3 * SRC_WORDS * 8 + 500;
        parsed = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
        for (int i = 0; i < t_name.size(); i++) begin
            e0 = errors;
            fill_memory(i);
            stall_mode = t_stall[i][0];
            if (t_abort[i] != 0) abort_run();
            for (int k = 0; k < t_runs[i]; k++) full_run();
            stall_mode = 1'b0;
            if (errors != e0) failed_tests++;
            $display("test %s: %s, %0d errors", t_name[i], (errors == e0) ? "ok" : "FAILED",
                errors - e0);
        end
        $display("tests %0d, failed %0d, errors %0d", t_name.size(), failed_tests, errors);
        if (errors == 0 && t_name.size() > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (parsed);
        repeat (limit) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tests/p2r_assertions.sv ====
// Control protocol assertions

module p2r_assertions (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 zeroize,
    input logic                 enable,
    input logic                 sk_buff_full,
    input logic                 done,
    input p2r_pkg::rd_state_e   rd_state,
    input p2r_pkg::mem_if_t     mem_rd_req
);
    import p2r_pkg::*;

    // back-pressure freezes the read request
    a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (sk_buff_full && !zeroize) |=> $stable(mem_rd_req))
        else $error("read request moved during back-pressure");

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done longer than one cycle");

    // idle read FSM issues no request until enabled
    a_idle_req: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_state == RD_IDLE && !enable) |=> (mem_rd_req.rd_wr_en == RW_IDLE))
        else $error("read request without enable");

endmodule

bind p2r_ctrl p2r_assertions u_p2r_assertions (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .enable       (enable),
    .sk_buff_full (sk_buff_full),
    .done         (done),
    .rd_state     (rd_state),
    .mem_rd_req   (mem_rd_req)
);

// ==== tests/tb_clock.sv ====
// Testbench clock source

module tb_clock (
    output logic clk
);
    // period of 10 time units
    initial clk = 1'b0;
    always #5 clk = ~clk;

endmodule

// ==== logic/p2r_top.sv ====
// Power2Round top level

module p2r_top (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize,
    input  logic                                enable,
    input  logic                                load_en,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]      load_addr,
    input  logic [p2r_pkg::COEFF_W-1:0]         load_data,
    input  logic                                sk_ready,
    output p2r_pkg::sk_word_t                   sk_wr,
    output logic                                pk_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]       pk_addr,
    output logic [1:0][p2r_pkg::T1_W-1:0]       pk_t1,
    output logic                                done
);
    import p2r_pkg::*;

    mem_if_t                mem_rd_req;
    coeff_pair_t            rd_pair;
    split_pair_t            split_pair;
    logic [SK_ADDR_W-1:0]   sk_addr;
    logic                   sk_pack_enable;
    logic                   sk_buff_valid;
    logic                   sk_buff_full;
    logic                   advance;

    // whole pipeline stalls on a blocked word
    assign advance = ~sk_buff_full;

    assign pk_t1 = split_pair.t1;

    coeff_mem u_coeff_mem (
        .clk            (clk),
        .reset_n        (reset_n),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .rd_req         (mem_rd_req),
        .advance        (advance),
        .rd_pair        (rd_pair)
    );

    p2r_ctrl u_p2r_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .sk_buff_valid  (sk_buff_valid),
        .sk_buff_full   (sk_buff_full),
        .mem_rd_req     (mem_rd_req),
        .sk_addr        (sk_addr),
        .sk_pack_enable (sk_pack_enable),
        .pk_wren        (pk_wren),
        .pk_addr        (pk_addr),
        .done           (done)
    );

    p2r_decompose u_p2r_decompose (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .advance        (advance),
        .in_pair        (rd_pair),
        .out_pair       (split_pair)
    );

    t0_packer u_t0_packer (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .in_pair        (split_pair),
        .sk_pack_enable (sk_pack_enable),
        .sk_addr        (sk_addr),
        .sk_ready       (sk_ready),
        .sk_wr          (sk_wr),
        .sk_buff_valid  (sk_buff_valid),
        .sk_buff_full   (sk_buff_full)
    );

endmodule

// ==== logic/t0_packer.sv ====
// Secret-key t0 packer

module t0_packer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  p2r_pkg::split_pair_t            in_pair,
    input  logic                            sk_pack_enable,
    input  logic [p2r_pkg::SK_ADDR_W-1:0]   sk_addr,
    input  logic                            sk_ready,
    output p2r_pkg::sk_word_t               sk_wr,
    output logic                            sk_buff_valid,
    output logic                            sk_buff_full
);
    import p2r_pkg::*;

    // first pair of a word waits here
    logic [1:0][T0_W-1:0]   half_t0;
    logic                   half_valid;

    // completed word waiting for the memory
    logic [4*T0_W-1:0]      word_data;
    logic                   pending;

    logic take;
    logic accept;

    assign sk_buff_full = pending & ~sk_ready;
    assign accept       = pending & sk_ready;
    assign take         = sk_pack_enable & in_pair.valid & ~sk_buff_full;

    // ------------------------------------------------------------------------
    // control flags
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            half_valid <= 1'b0;
            pending    <= 1'b0;
        end else begin
            if (accept) begin
                pending <= 1'b0;
            end
            if (take) begin
                if (!half_valid) begin
                    half_valid <= 1'b1;
                end else begin
                    // a new word can replace one accepted this cycle
                    half_valid <= 1'b0;
                    pending    <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // data path
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (take && !half_valid) begin
            half_t0 <= in_pair.t0;
        end
        if (take && half_valid) begin
            // lowest coefficient in the lowest bits
            word_data <= {in_pair.t0[1], in_pair.t0[0], half_t0[1], half_t0[0]};
        end
    end

    assign sk_buff_valid = pending;

    assign sk_wr.en   = pending;
    assign sk_wr.addr = sk_addr;
    assign sk_wr.data = word_data;

endmodule

// ==== logic/p2r_decompose.sv ====
// Power2Round split stage

module p2r_decompose (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    advance,
    input  p2r_pkg::coeff_pair_t    in_pair,
    output p2r_pkg::split_pair_t    out_pair
);
    import p2r_pkg::*;

    logic [1:0][T1_W-1:0]   t1_comb, t1_q;
    logic [1:0][T0_W-1:0]   t0_comb, t0_q;
    logic                   valid_q;

    // t1 = (t + 2^(d-1) - 1) >> d
    // t0 = t - t1 * 2^d, sent as 2^(d-1) - t0
    always_comb begin
        logic [COEFF_W:0] rounded;
        logic [COEFF_W:0] hi_part;
        logic [COEFF_W:0] enc;
        for (int i = 0; i < 2; i++) begin
            rounded    = {1'b0, in_pair.coeff[i]} + (COEFF_W + 1)'((1 << (P2R_D - 1)) - 1);
            t1_comb[i] = rounded[P2R_D +: T1_W];
            hi_part    = (COEFF_W + 1)'(t1_comb[i]) << P2R_D;
            enc        = hi_part + (COEFF_W + 1)'(1 << (P2R_D - 1))
                         - {1'b0, in_pair.coeff[i]};
            // encoded value always lies in 0 .. 2^d - 1
            t0_comb[i] = enc[T0_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            t1_q <= t1_comb;
            t0_q <= t0_comb;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= in_pair.valid;
        end
    end

    assign out_pair.valid = valid_q;
    assign out_pair.t1    = t1_q;
    assign out_pair.t0    = t0_q;

endmodule

// ==== logic/p2r_ctrl.sv ====
// Power2Round sequencing control

module p2r_ctrl (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            enable,
    input  logic                            sk_buff_valid,
    input  logic                            sk_buff_full,
    output p2r_pkg::mem_if_t                mem_rd_req,
    output logic [p2r_pkg::SK_ADDR_W-1:0]   sk_addr,
    output logic                            sk_pack_enable,
    output logic                            pk_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]   pk_addr,
    output logic                            done
);
    import p2r_pkg::*;

    rd_state_e  rd_state, rd_state_nxt;
    sk_state_e  sk_state, sk_state_nxt;
    pk_state_e  pk_state, pk_state_nxt;

    logic [MEM_ADDR_W-1:0]  rd_addr;
    logic [SK_ADDR_W-1:0]   sk_wr_addr;
    logic [PK_ADDR_W-1:0]   pk_wr_addr;

    logic advance;
    logic sk_accept;
    logic last_rd, last_sk, last_pk;
    // mirrors of the memory and decompose valid flags
    logic stage1_vld, stage2_vld;

    assign advance   = ~sk_buff_full;
    assign sk_accept = sk_buff_valid & ~sk_buff_full;

    assign last_rd = (rd_addr == MEM_ADDR_W'(SRC_WORDS - 2));
    assign last_sk = (sk_wr_addr == SK_ADDR_W'(SK_WORDS - 1));
    assign last_pk = (pk_wr_addr == PK_ADDR_W'(PK_PAIRS - 1));

    // ------------------------------------------------------------------------
    // state and address registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            rd_state   <= RD_IDLE;
            sk_state   <= SK_IDLE;
            pk_state   <= PK_IDLE;
            rd_addr    <= '0;
            sk_wr_addr <= '0;
            pk_wr_addr <= '0;
            stage1_vld <= 1'b0;
            stage2_vld <= 1'b0;
            done       <= 1'b0;
        end else begin
            rd_state <= rd_state_nxt;
            sk_state <= sk_state_nxt;
            pk_state <= pk_state_nxt;

            if (rd_state == RD_IDLE) begin
                rd_addr <= '0;
            end else if (rd_state == RD_MEM && advance && !last_rd) begin
                rd_addr <= rd_addr + MEM_ADDR_W'(2);
            end

            if (sk_state == SK_IDLE) begin
                sk_wr_addr <= '0;
            end else if (sk_state == SK_MEM && sk_accept && !last_sk) begin
                sk_wr_addr <= sk_wr_addr + SK_ADDR_W'(1);
            end

            if (pk_state == PK_IDLE) begin
                pk_wr_addr <= '0;
            end else if (pk_wren && !last_pk) begin
                pk_wr_addr <= pk_wr_addr + PK_ADDR_W'(1);
            end

            // follow the two pipeline registers
            if (advance) begin
                stage1_vld <= (rd_state == RD_MEM);
                stage2_vld <= stage1_vld;
            end

            done <= (sk_state == SK_DONE);
        end
    end

    // ------------------------------------------------------------------------
    // next-state logic
    // ------------------------------------------------------------------------

    // read FSM, one pair per advancing cycle
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            RD_IDLE: if (enable) rd_state_nxt = RD_MEM;
            RD_MEM:  if (advance && last_rd) rd_state_nxt = RD_DONE;
            // hold until the last word has gone out
            RD_DONE: if (sk_state == SK_DONE) rd_state_nxt = RD_IDLE;
            default: rd_state_nxt = RD_IDLE;
        endcase
    end

    // secret-key FSM, one wait cycle then count accepted words
    always_comb begin
        sk_state_nxt = sk_state;
        case (sk_state)
            SK_IDLE: if (rd_state == RD_MEM) sk_state_nxt = SK_WAIT;
            SK_WAIT: sk_state_nxt = SK_MEM;
            SK_MEM:  if (sk_accept && last_sk) sk_state_nxt = SK_DONE;
            SK_DONE: sk_state_nxt = SK_IDLE;
            default: sk_state_nxt = SK_IDLE;
        endcase
    end

    // public-key FSM, one t1 write per pair
    always_comb begin
        pk_state_nxt = pk_state;
        case (pk_state)
            PK_IDLE:  if (rd_state == RD_MEM) pk_state_nxt = PK_WRITE;
            PK_WRITE: if (pk_wren && last_pk) pk_state_nxt = PK_DONE;
            PK_DONE:  pk_state_nxt = PK_IDLE;
            default:  pk_state_nxt = PK_IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------

    assign mem_rd_req.rd_wr_en = (rd_state == RD_MEM) ? RW_READ : RW_IDLE;
    assign mem_rd_req.addr     = rd_addr;

    assign sk_pack_enable = (sk_state == SK_MEM) & stage2_vld & advance;
    assign pk_wren        = (pk_state == PK_WRITE) & stage2_vld & advance;

    assign sk_addr = sk_wr_addr;
    assign pk_addr = pk_wr_addr;

endmodule

// ==== logic/coeff_mem.sv ====
// Source coefficient memory

module coeff_mem (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            load_en,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]  load_addr,
    input  logic [p2r_pkg::COEFF_W-1:0]     load_data,
    input  p2r_pkg::mem_if_t                rd_req,
    input  logic                            advance,
    output p2r_pkg::coeff_pair_t            rd_pair
);
    import p2r_pkg::*;

    logic [COEFF_W-1:0]     mem [SRC_WORDS];
    logic [MEM_ADDR_W-1:0]  addr_b;
    logic [1:0][COEFF_W-1:0] rd_data;
    logic                   rd_valid;

    // second port reads the odd neighbour
    assign addr_b = rd_req.addr + MEM_ADDR_W'(1);

    // load port, used while the datapath is idle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rd_data[0] <= mem[rd_req.addr];
            rd_data[1] <= mem[addr_b];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else if (advance) begin
            rd_valid <= (rd_req.rd_wr_en == RW_READ);
        end
    end

    assign rd_pair.valid = rd_valid;
    assign rd_pair.coeff = rd_data;

endmodule

// ==== logic/p2r_pkg.sv ====
// Power2Round shared definitions

package p2r_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------

    // scaled-down polynomial count and length
    localparam int P2R_K = 2;
    localparam int P2R_N = 32;

    // dropped low bits of the split
    localparam int P2R_D = 13;

    localparam int COEFF_W = 23;
    localparam int T1_W    = 10;
    localparam int T0_W    = 13;

    localparam int SRC_WORDS = P2R_K * P2R_N;
    localparam int SK_WORDS  = (P2R_K * P2R_N) / 4;
    localparam int PK_PAIRS  = (P2R_K * P2R_N) / 2;

    localparam int MEM_ADDR_W = $clog2(SRC_WORDS);
    localparam int SK_ADDR_W  = $clog2(SK_WORDS);
    localparam int PK_ADDR_W  = $clog2(PK_PAIRS);

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_op_e;

    typedef struct packed {
        rw_op_e                  rd_wr_en;
        logic [MEM_ADDR_W-1:0]   addr;
    } mem_if_t;

    // coefficient pair from the source memory
    typedef struct packed {
        logic                       valid;
        logic [1:0][COEFF_W-1:0]    coeff;
    } coeff_pair_t;

    // high parts and encoded low parts of a pair
    typedef struct packed {
        logic                       valid;
        logic [1:0][T1_W-1:0]       t1;
        logic [1:0][T0_W-1:0]       t0;
    } split_pair_t;

    typedef struct packed {
        logic                       en;
        logic [SK_ADDR_W-1:0]       addr;
        logic [4*T0_W-1:0]          data;
    } sk_word_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_MEM,
        RD_DONE
    } rd_state_e;

    typedef enum logic [1:0] {
        SK_IDLE,
        SK_WAIT,
        SK_MEM,
        SK_DONE
    } sk_state_e;

    typedef enum logic [1:0] {
        PK_IDLE,
        PK_WRITE,
        PK_DONE
    } pk_state_e;

endpackage
